//--- dps_chip.f
verilog/dps_pkg.sv
verilog/pad_mux.sv
verilog/spi_device.sv
verilog/jtag_tap.sv
verilog/main_ram.sv
verilog/status_monitor.sv
verilog/dps_chip.sv
verif/tb_dps_chip.sv

//--- Makefile
# Verilator build and run for the dps_chip subsystem

VERILATOR ?= verilator
TOP       ?= tb_dps_chip
FILELIST  ?= dps_chip.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_dps_chip.sv
////////////////////
// Testbench for dps_chip: drives SPI frames and JTAG scans on the shared
// pads with seeded random data, checks against a RAM and status model
////////////////////

`timescale 1ns/1ps

module tb_dps_chip;

  localparam int RAM_DEPTH = 64;
  localparam int ADDR_W    = $clog2(RAM_DEPTH);
  localparam int HALF      = 4;
  localparam int LOG_ADDR  = RAM_DEPTH - 2;
  localparam int STAT_ADDR = RAM_DEPTH - 1;
  // Twice about 500 SPI frames of about 400 cycles each
  localparam int FRAME_CYCLES   = 400;
  localparam int TIMEOUT_CYCLES = 2 * 500 * FRAME_CYCLES;

  logic                       clk;
  logic                       rst_n;
  logic [7:0]                 pads;
  logic                       dps_o;
  dps_pkg::test_status_e      test_status;
  logic                       test_passed;
  logic                       test_failed;
  logic                       sw_log_valid;
  logic [dps_pkg::WORD_W-1:0] sw_log_data;

  logic [31:0] model [RAM_DEPTH];
  logic [15:0] model_status;
  int          checks;
  int          errors;
  int          log_count;
  logic [31:0] log_data;
  int          cycles;

  dps_chip #(.RAM_DEPTH(RAM_DEPTH)) dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .dps_i          (pads),
    .dps_o          (dps_o),
    .test_status_o  (test_status),
    .test_passed_o  (test_passed),
    .test_failed_o  (test_failed),
    .sw_log_valid_o (sw_log_valid),
    .sw_log_data_o  (sw_log_data)
  );

  always #20 clk = ~clk;

  // Log strobes counted away from the active edge
  always @(negedge clk) begin
    if (sw_log_valid) begin
      log_count = log_count + 1;
      log_data  = sw_log_data;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic pause(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status();
    compare_word("test status", 32'(test_status), 32'(model_status));
    compare_word("test passed", 32'(test_passed), 32'(model_status == dps_pkg::TS_PASSED));
    compare_word("test failed", 32'(test_failed), 32'(model_status == dps_pkg::TS_FAILED));
  endtask

  // Upper address bits are ignored by the device
  function automatic logic [7:0] random_addr_byte(input logic [ADDR_W-1:0] addr);
    logic [7:0] b;
    b = 8'($urandom);
    b[ADDR_W-1:0] = addr;
    return b;
  endfunction

  function automatic logic [15:0] status_code(input int n);
    case (n % 4)
      0:       return dps_pkg::TS_IN_TEST;
      1:       return dps_pkg::TS_PASSED;
      2:       return dps_pkg::TS_FAILED;
      default: return 16'($urandom);
    endcase
  endfunction

  // Mode 0 master that moves mosi with sck low and samples miso before each rise
  task automatic send_frame(input logic [7:0] op, input logic [7:0] addr_byte,
                            input logic [31:0] wdata, input int nbits,
                            output logic [47:0] rx);
    logic [47:0] tx;
    tx = {op, addr_byte, wdata};
    rx = '0;
    pads[3] = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      pads[1] = tx[47-i];
      pause(HALF);
      rx[47-i] = dps_o;
      pads[0] = 1'b1;
      pause(HALF);
      pads[0] = 1'b0;
    end
    pause(HALF);
    pads[3] = 1'b1;
    pads[1] = 1'b0;
    pause(2 * HALF);
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    logic [47:0] rx;
    int          pulses_before;
    int          exp_pulses;
    pulses_before = log_count;
    exp_pulses    = 0;
    send_frame(dps_pkg::SPI_WRITE, random_addr_byte(addr), data, 48, rx);
    // Writes only land while bootstrap is high
    if (pads[7]) begin
      model[addr] = data;
      if (addr == ADDR_W'(STAT_ADDR)) model_status = data[15:0];
      if (addr == ADDR_W'(LOG_ADDR)) exp_pulses = 1;
    end
    compare_word("miso during write frame", rx[31:0], '0);
    compare_word("miso during write header", 32'(rx[47:32]), '0);
    compare_word("log pulse count", 32'(log_count - pulses_before), 32'(exp_pulses));
    if (exp_pulses == 1) compare_word("log data", log_data, data);
    check_status();
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr);
    logic [47:0] rx;
    send_frame(dps_pkg::SPI_READ, random_addr_byte(addr), 32'($urandom), 48, rx);
    compare_word("miso during read header", 32'(rx[47:32]), '0);
    compare_word($sformatf("read data of word %0d", addr), rx[31:0], model[addr]);
  endtask

  // Write frame cut short by csb leaves RAM and monitor alone
  task automatic abort_frame();
    logic [47:0] rx;
    int          pulses_before;
    pulses_before = log_count;
    send_frame(dps_pkg::SPI_WRITE, random_addr_byte(ADDR_W'($urandom_range(RAM_DEPTH - 1))),
               32'($urandom), int'($urandom_range(47, 1)), rx);
    compare_word("miso during aborted frame", rx[31:0], '0);
    compare_word("log pulse count after abort", 32'(log_count - pulses_before), '0);
    check_status();
  endtask

  task automatic clock_tap(input logic tms, input logic tdi, output logic tdo);
    pads[3] = tms;
    pads[1] = tdi;
    pause(HALF);
    tdo = dps_o;
    pads[0] = 1'b1;
    pause(HALF);
    pads[0] = 1'b0;
  endtask

  // Run-Test/Idle through a 32-bit DR scan and back with LSB first
  task automatic scan_dr(input logic [31:0] tdi_bits, output logic [31:0] tdo_bits);
    logic ignored;
    logic bit_out;
    clock_tap(1'b1, 1'b0, ignored);
    clock_tap(1'b0, 1'b0, ignored);
    clock_tap(1'b0, 1'b0, ignored);
    for (int i = 0; i < 32; i++) begin
      clock_tap(i == 31, tdi_bits[i], bit_out);
      tdo_bits[i] = bit_out;
    end
    clock_tap(1'b1, 1'b0, ignored);
    clock_tap(1'b0, 1'b0, ignored);
  endtask

  task automatic load_ir(input logic [dps_pkg::IR_W-1:0] code);
    logic                      ignored;
    logic                      bit_out;
    logic [dps_pkg::IR_W-1:0] captured;
    clock_tap(1'b1, 1'b0, ignored);
    clock_tap(1'b1, 1'b0, ignored);
    clock_tap(1'b0, 1'b0, ignored);
    clock_tap(1'b0, 1'b0, ignored);
    for (int i = 0; i < dps_pkg::IR_W; i++) begin
      clock_tap(i == dps_pkg::IR_W - 1, code[i], bit_out);
      captured[i] = bit_out;
    end
    clock_tap(1'b1, 1'b0, ignored);
    clock_tap(1'b0, 1'b0, ignored);
    // Capture-IR loads 01 in the low bits
    compare_word("IR capture value", 32'(captured), 32'd1);
  endtask

  // Pads parked idle before the strap moves
  task automatic select_jtag(input logic on);
    pads[0] = 1'b0;
    pads[1] = 1'b0;
    pads[3] = 1'b1;
    pause(HALF);
    pads[6] = on;
    pause(2 * HALF);
  endtask

  initial begin
    logic [31:0] tdo_bits;
    logic [31:0] tdi_bits;
    logic        ignored;
    clk          = 1'b0;
    rst_n        = 1'b0;
    // Bootstrap high and SPI mode with csb, trst_n and srst_n idle high
    pads         = 8'b1011_1000;
    checks       = 0;
    errors       = 0;
    log_count    = 0;
    cycles       = 0;
    model_status = dps_pkg::TS_BOOT;
    void'($urandom(23));
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    pause(HALF);
    check_status();
    compare_word("log valid after reset", 32'(sw_log_valid), '0);
    compare_word("RAM request after reset", 32'(dut.ram_req), '0);
    compare_word("TAP state after reset", 32'(dut.u_jtag_tap.state_q),
                 32'(dps_pkg::TAP_RESET));

    // Known contents below the log and status words
    for (int a = 0; a < LOG_ADDR; a++) write_word(ADDR_W'(a), $urandom);

    for (int n = 0; n < 60; n++) begin
      if ($urandom_range(1) == 1) begin
        write_word(ADDR_W'($urandom_range(LOG_ADDR - 1)), $urandom);
      end else begin
        read_word(ADDR_W'($urandom_range(LOG_ADDR - 1)));
      end
    end

    // Writes with bootstrap low and then short frames
    pads[7] = 1'b0;
    for (int n = 0; n < 20; n++) write_word(ADDR_W'($urandom_range(LOG_ADDR - 1)), $urandom);
    for (int n = 0; n < 10; n++) read_word(ADDR_W'($urandom_range(LOG_ADDR - 1)));
    pads[7] = 1'b1;
    for (int n = 0; n < 20; n++) abort_frame();
    for (int n = 0; n < 10; n++) read_word(ADDR_W'($urandom_range(LOG_ADDR - 1)));

    // Log word and status word
    for (int n = 0; n < 8; n++) write_word(ADDR_W'(LOG_ADDR), $urandom);
    for (int n = 0; n < 8; n++) write_word(ADDR_W'(STAT_ADDR), {16'($urandom), status_code(n)});
    write_word(ADDR_W'(STAT_ADDR), {16'($urandom), dps_pkg::TS_PASSED});
    pads[5] = 1'b0;
    pause(HALF);
    pads[5] = 1'b1;
    pause(HALF);
    model_status = dps_pkg::TS_BOOT;
    check_status();

    // JTAG scans for IDCODE and BYPASS, then trst_n and TMS resets
    select_jtag(1'b1);
    clock_tap(1'b0, 1'b0, ignored);
    scan_dr('0, tdo_bits);
    compare_word("IDCODE after chip reset", tdo_bits, dps_pkg::JTAG_IDCODE);
    load_ir(dps_pkg::IR_BYPASS);
    tdi_bits = $urandom;
    scan_dr(tdi_bits, tdo_bits);
    compare_word("BYPASS scan", tdo_bits, {tdi_bits[30:0], 1'b0});
    compare_word("pad 2 with TAP idle", 32'(dps_o), '0);
    // trst_n clears both the state and the IR
    pads[4] = 1'b0;
    pause(HALF);
    pads[4] = 1'b1;
    pause(HALF);
    clock_tap(1'b0, 1'b0, ignored);
    scan_dr('0, tdo_bits);
    compare_word("IDCODE after trst_n", tdo_bits, dps_pkg::JTAG_IDCODE);
    load_ir(dps_pkg::IR_BYPASS);
    for (int n = 0; n < 5; n++) clock_tap(1'b1, 1'b0, ignored);
    clock_tap(1'b0, 1'b0, ignored);
    scan_dr('0, tdo_bits);
    compare_word("IDCODE after TMS reset", tdo_bits, dps_pkg::JTAG_IDCODE);

    // Random pad activity while JTAG owns the pads
    for (int n = 0; n < 200; n++) begin
      pads[0] = 1'($urandom);
      pads[1] = 1'($urandom);
      pads[3] = 1'($urandom);
      pause(1);
    end
    select_jtag(1'b0);
    compare_word("pad 2 in SPI idle", 32'(dps_o), '0);
    for (int a = 0; a < LOG_ADDR; a++) read_word(ADDR_W'(a));

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- verilog/dps_chip.sv
////////////////////
// Chip-level pad subsystem: shared JTAG/SPI pads, word RAM and status monitor
// RAM_DEPTH sets the word count for all blocks below
////////////////////

`timescale 1ns/1ps

module dps_chip #(
  parameter int RAM_DEPTH = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [7:0]                 dps_i,
  output logic                       dps_o,
  output dps_pkg::test_status_e      test_status_o,
  output logic                       test_passed_o,
  output logic                       test_failed_o,
  output logic                       sw_log_valid_o,
  output logic [dps_pkg::WORD_W-1:0] sw_log_data_o
);

  localparam int ADDR_W = $clog2(RAM_DEPTH);

  logic spi_sck_rise, spi_sck_fall, spi_csb, spi_mosi, spi_miso, write_en;
  logic tck_rise, tck_fall, tms, tdi, tdo, trst_n, srst_n;
  logic                       ram_req;
  logic                       ram_we;
  logic [ADDR_W-1:0]          ram_addr;
  logic [dps_pkg::WORD_W-1:0] ram_wdata;
  logic [dps_pkg::WORD_W-1:0] ram_rdata;

  pad_mux u_pad_mux (
    .clk_i, .rst_n_i, .dps_i,
    .tdo_i          (tdo),
    .miso_i         (spi_miso),
    .dps_o,
    .spi_sck_rise_o (spi_sck_rise),
    .spi_sck_fall_o (spi_sck_fall),
    .spi_csb_o      (spi_csb),
    .spi_mosi_o     (spi_mosi),
    .write_en_o     (write_en),
    .tck_rise_o     (tck_rise),
    .tck_fall_o     (tck_fall),
    .tms_o          (tms),
    .tdi_o          (tdi),
    .trst_n_o       (trst_n),
    .srst_n_o       (srst_n)
  );

  spi_device #(.RAM_DEPTH(RAM_DEPTH)) u_spi_device (
    .clk_i, .rst_n_i,
    .sck_rise_i  (spi_sck_rise),
    .sck_fall_i  (spi_sck_fall),
    .csb_i       (spi_csb),
    .mosi_i      (spi_mosi),
    .write_en_i  (write_en),
    .ram_rdata_i (ram_rdata),
    .miso_o      (spi_miso),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata)
  );

  jtag_tap u_jtag_tap (
    .clk_i, .rst_n_i,
    .tck_rise_i (tck_rise),
    .tck_fall_i (tck_fall),
    .tms_i      (tms),
    .tdi_i      (tdi),
    .trst_n_i   (trst_n),
    .tdo_o      (tdo)
  );

  main_ram #(.RAM_DEPTH(RAM_DEPTH)) u_main_ram (
    .clk_i,
    .req_i   (ram_req),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  // Snoops the same request the RAM sees
  status_monitor #(.RAM_DEPTH(RAM_DEPTH)) u_status_monitor (
    .clk_i, .rst_n_i,
    .srst_n_i (srst_n),
    .req_i    (ram_req),
    .we_i     (ram_we),
    .addr_i   (ram_addr),
    .wdata_i  (ram_wdata),
    .test_status_o, .test_passed_o, .test_failed_o,
    .sw_log_valid_o, .sw_log_data_o
  );

endmodule

//--- verilog/status_monitor.sv
////////////////////
// Watches RAM writes: the top word carries the test status,
// the word below it is a software log port
////////////////////

`timescale 1ns/1ps

module status_monitor #(
  parameter int RAM_DEPTH = 64
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         srst_n_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] addr_i,
  input  logic [dps_pkg::WORD_W-1:0]   wdata_i,
  output dps_pkg::test_status_e        test_status_o,
  output logic                         test_passed_o,
  output logic                         test_failed_o,
  output logic                         sw_log_valid_o,
  output logic [dps_pkg::WORD_W-1:0]   sw_log_data_o
);

  localparam int ADDR_W = $clog2(RAM_DEPTH);
  localparam logic [ADDR_W-1:0] STATUS_ADDR = ADDR_W'(RAM_DEPTH - 1);
  localparam logic [ADDR_W-1:0] LOG_ADDR    = ADDR_W'(RAM_DEPTH - 2);

  logic wr_status;
  logic wr_log;

  assign wr_status = req_i && we_i && (addr_i == STATUS_ADDR);
  assign wr_log    = req_i && we_i && (addr_i == LOG_ADDR);

  // Software reset pad also returns status to boot
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !srst_n_i) begin
      test_status_o <= dps_pkg::TS_BOOT;
    end else if (wr_status) begin
      test_status_o <= dps_pkg::test_status_e'(wdata_i[15:0]);
    end
  end

  assign test_passed_o = (test_status_o == dps_pkg::TS_PASSED);
  assign test_failed_o = (test_status_o == dps_pkg::TS_FAILED);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sw_log_valid_o <= 1'b0;
    end else begin
      sw_log_valid_o <= wr_log;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_log) begin
      sw_log_data_o <= wdata_i;
    end
  end

endmodule

//--- verilog/main_ram.sv
////////////////////
// Single-port word RAM, one cycle read latency
////////////////////

`timescale 1ns/1ps

module main_ram #(
  parameter int RAM_DEPTH = 64
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] addr_i,
  input  logic [dps_pkg::WORD_W-1:0]   wdata_i,
  output logic [dps_pkg::WORD_W-1:0]   rdata_o
);

  logic [dps_pkg::WORD_W-1:0] mem [RAM_DEPTH];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        // Data valid the cycle after the request
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- verilog/jtag_tap.sv
////////////////////
// JTAG TAP controller running off oversampled tck edges
// Supports IDCODE and BYPASS, all other IR codes act as BYPASS
////////////////////

`timescale 1ns/1ps

module jtag_tap (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic tck_rise_i,
  input  logic tck_fall_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic trst_n_i,
  output logic tdo_o
);

  localparam int IR_W = dps_pkg::IR_W;

  dps_pkg::tap_state_e state_q;
  dps_pkg::tap_state_e state_d;
  dps_pkg::jtag_ir_e   ir_q;
  logic [IR_W-1:0]     ir_sr_q;
  logic [31:0]         dr_sr_q;
  logic                bypass_q;
  logic                sel_bypass;

  // Standard 1149.1 state transitions
  always_comb begin
    state_d = state_q;
    case (state_q)
      dps_pkg::TAP_RESET:      state_d = tms_i ? dps_pkg::TAP_RESET     : dps_pkg::TAP_IDLE;
      dps_pkg::TAP_IDLE:       state_d = tms_i ? dps_pkg::TAP_SELECT_DR : dps_pkg::TAP_IDLE;
      dps_pkg::TAP_SELECT_DR:  state_d = tms_i ? dps_pkg::TAP_SELECT_IR : dps_pkg::TAP_CAPTURE_DR;
      dps_pkg::TAP_CAPTURE_DR: state_d = tms_i ? dps_pkg::TAP_EXIT1_DR  : dps_pkg::TAP_SHIFT_DR;
      dps_pkg::TAP_SHIFT_DR:   state_d = tms_i ? dps_pkg::TAP_EXIT1_DR  : dps_pkg::TAP_SHIFT_DR;
      dps_pkg::TAP_EXIT1_DR:   state_d = tms_i ? dps_pkg::TAP_UPDATE_DR : dps_pkg::TAP_PAUSE_DR;
      dps_pkg::TAP_PAUSE_DR:   state_d = tms_i ? dps_pkg::TAP_EXIT2_DR  : dps_pkg::TAP_PAUSE_DR;
      dps_pkg::TAP_EXIT2_DR:   state_d = tms_i ? dps_pkg::TAP_UPDATE_DR : dps_pkg::TAP_SHIFT_DR;
      dps_pkg::TAP_UPDATE_DR:  state_d = tms_i ? dps_pkg::TAP_SELECT_DR : dps_pkg::TAP_IDLE;
      dps_pkg::TAP_SELECT_IR:  state_d = tms_i ? dps_pkg::TAP_RESET     : dps_pkg::TAP_CAPTURE_IR;
      dps_pkg::TAP_CAPTURE_IR: state_d = tms_i ? dps_pkg::TAP_EXIT1_IR  : dps_pkg::TAP_SHIFT_IR;
      dps_pkg::TAP_SHIFT_IR:   state_d = tms_i ? dps_pkg::TAP_EXIT1_IR  : dps_pkg::TAP_SHIFT_IR;
      dps_pkg::TAP_EXIT1_IR:   state_d = tms_i ? dps_pkg::TAP_UPDATE_IR : dps_pkg::TAP_PAUSE_IR;
      dps_pkg::TAP_PAUSE_IR:   state_d = tms_i ? dps_pkg::TAP_EXIT2_IR  : dps_pkg::TAP_PAUSE_IR;
      dps_pkg::TAP_EXIT2_IR:   state_d = tms_i ? dps_pkg::TAP_UPDATE_IR : dps_pkg::TAP_SHIFT_IR;
      dps_pkg::TAP_UPDATE_IR:  state_d = tms_i ? dps_pkg::TAP_SELECT_DR : dps_pkg::TAP_IDLE;
      default:                 state_d = dps_pkg::TAP_RESET;
    endcase
  end

  always_comb begin
    case (ir_q)
      dps_pkg::IR_IDCODE: sel_bypass = 1'b0;
      dps_pkg::IR_BYPASS: sel_bypass = 1'b1;
      default:            sel_bypass = 1'b1;
    endcase
  end

  // State, instruction and tdo, cleared by chip reset or trst_n
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !trst_n_i) begin
      state_q <= dps_pkg::TAP_RESET;
      ir_q    <= dps_pkg::IR_IDCODE;
      tdo_o   <= 1'b0;
    end else begin
      if (tck_rise_i) begin
        state_q <= state_d;
      end
      if (state_q == dps_pkg::TAP_RESET) begin
        ir_q <= dps_pkg::IR_IDCODE;
      end else if (tck_fall_i && state_q == dps_pkg::TAP_UPDATE_IR) begin
        ir_q <= dps_pkg::jtag_ir_e'(ir_sr_q);
      end
      // tdo changes on the falling edge only
      if (tck_fall_i) begin
        if (state_q == dps_pkg::TAP_SHIFT_IR) begin
          tdo_o <= ir_sr_q[0];
        end else if (state_q == dps_pkg::TAP_SHIFT_DR) begin
          tdo_o <= sel_bypass ? bypass_q : dr_sr_q[0];
        end else begin
          tdo_o <= 1'b0;
        end
      end
    end
  end

  // Shift paths, LSB out first
  always_ff @(posedge clk_i) begin
    if (tck_rise_i) begin
      case (state_q)
        dps_pkg::TAP_CAPTURE_IR: ir_sr_q <= {{(IR_W - 1){1'b0}}, 1'b1};
        dps_pkg::TAP_SHIFT_IR:   ir_sr_q <= {tdi_i, ir_sr_q[IR_W-1:1]};
        dps_pkg::TAP_CAPTURE_DR: begin
          dr_sr_q  <= dps_pkg::JTAG_IDCODE;
          bypass_q <= 1'b0;
        end
        dps_pkg::TAP_SHIFT_DR: begin
          dr_sr_q  <= {tdi_i, dr_sr_q[31:1]};
          bypass_q <= tdi_i;
        end
        default: bypass_q <= bypass_q;
      endcase
    end
  end

endmodule

//--- verilog/spi_device.sv
////////////////////
// SPI mode-0 slave: opcode byte, address byte, then 32 data bits MSB first
// Write and read frames turn into single-cycle RAM requests
////////////////////

`timescale 1ns/1ps

module spi_device #(
  parameter int RAM_DEPTH = 64
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         sck_rise_i,
  input  logic                         sck_fall_i,
  input  logic                         csb_i,
  input  logic                         mosi_i,
  input  logic                         write_en_i,
  input  logic [dps_pkg::WORD_W-1:0]   ram_rdata_i,
  output logic                         miso_o,
  output logic                         ram_req_o,
  output logic                         ram_we_o,
  output logic [$clog2(RAM_DEPTH)-1:0] ram_addr_o,
  output logic [dps_pkg::WORD_W-1:0]   ram_wdata_o
);

  localparam int ADDR_W = $clog2(RAM_DEPTH);
  localparam int W      = dps_pkg::WORD_W;

  typedef enum logic [1:0] {
    PH_OPCODE,
    PH_ADDR,
    PH_DATA,
    PH_IGNORE
  } phase_e;

  phase_e         phase_q;
  logic [4:0]     bit_cnt_q;
  logic           is_read_q;
  logic           rd_pend_q;
  logic [W-1:0]   rx_sr_q;
  logic [W-1:0]   tx_sr_q;
  logic [7:0]     rx_byte;

  // Byte completed by the current sck rise
  assign rx_byte = {rx_sr_q[6:0], mosi_i};

  assign miso_o      = tx_sr_q[W-1];
  assign ram_wdata_o = rx_sr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      phase_q   <= PH_OPCODE;
      bit_cnt_q <= '0;
      is_read_q <= 1'b0;
      rd_pend_q <= 1'b0;
      ram_req_o <= 1'b0;
      ram_we_o  <= 1'b0;
      tx_sr_q   <= '0;
    end else begin
      ram_req_o <= 1'b0;
      rd_pend_q <= ram_req_o && !ram_we_o;
      if (csb_i) begin
        // Frame over, a partial one is simply dropped
        phase_q   <= PH_OPCODE;
        bit_cnt_q <= '0;
        tx_sr_q   <= '0;
      end else begin
        // Read data lands one cycle after the request
        if (rd_pend_q && phase_q == PH_DATA) begin
          tx_sr_q <= ram_rdata_i;
        end else if (sck_fall_i && phase_q == PH_DATA && is_read_q && bit_cnt_q != '0) begin
          tx_sr_q <= {tx_sr_q[W-2:0], 1'b0};
        end
        if (sck_rise_i) begin
          bit_cnt_q <= bit_cnt_q + 5'd1;
          case (phase_q)
            PH_OPCODE: begin
              if (bit_cnt_q == 5'd7) begin
                bit_cnt_q <= '0;
                case (rx_byte)
                  dps_pkg::SPI_WRITE: begin
                    phase_q   <= PH_ADDR;
                    is_read_q <= 1'b0;
                  end
                  dps_pkg::SPI_READ: begin
                    phase_q   <= PH_ADDR;
                    is_read_q <= 1'b1;
                  end
                  default: phase_q <= PH_IGNORE;
                endcase
              end
            end
            PH_ADDR: begin
              if (bit_cnt_q == 5'd7) begin
                bit_cnt_q <= '0;
                phase_q   <= PH_DATA;
                // Fetch early so bit 31 is ready before the first data edge
                ram_req_o <= is_read_q;
                ram_we_o  <= 1'b0;
              end
            end
            PH_DATA: begin
              if (bit_cnt_q == 5'd31) begin
                phase_q   <= PH_IGNORE;
                tx_sr_q   <= '0;
                ram_req_o <= !is_read_q && write_en_i;
                ram_we_o  <= !is_read_q;
              end
            end
            default: bit_cnt_q <= bit_cnt_q;
          endcase
        end
      end
    end
  end

  // Receive shift register and latched address
  always_ff @(posedge clk_i) begin
    if (sck_rise_i && !csb_i) begin
      rx_sr_q <= {rx_sr_q[W-2:0], mosi_i};
      if (phase_q == PH_ADDR && bit_cnt_q == 5'd7) begin
        ram_addr_o <= rx_byte[ADDR_W-1:0];
      end
    end
  end

endmodule

//--- verilog/pad_mux.sv
////////////////////
// Pad front end: synchronizes the shared pads and steers them to the
// JTAG TAP or the SPI device depending on the jtag_spi_n strap
////////////////////

`timescale 1ns/1ps

module pad_mux (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [7:0] dps_i,
  input  logic       tdo_i,
  input  logic       miso_i,
  output logic       dps_o,
  output logic       spi_sck_rise_o,
  output logic       spi_sck_fall_o,
  output logic       spi_csb_o,
  output logic       spi_mosi_o,
  output logic       write_en_o,
  output logic       tck_rise_o,
  output logic       tck_fall_o,
  output logic       tms_o,
  output logic       tdi_o,
  output logic       trst_n_o,
  output logic       srst_n_o
);

  // Idle levels: csb/tms, trst_n and srst_n high
  localparam logic [7:0] PAD_IDLE = 8'b0011_1000;

  logic [7:0] pad_meta;
  logic [7:0] pad_sync;
  logic       clk_pad_prev;
  logic       clk_pad_rise;
  logic       clk_pad_fall;
  logic       jtag_mode;

  // Two-flop synchronizers, pad 2 is our output so its flops stay at zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pad_meta     <= PAD_IDLE;
      pad_sync     <= PAD_IDLE;
      clk_pad_prev <= 1'b0;
    end else begin
      pad_meta     <= dps_i & 8'b1111_1011;
      pad_sync     <= pad_meta;
      clk_pad_prev <= pad_sync[0];
    end
  end

  assign clk_pad_rise = pad_sync[0] && !clk_pad_prev;
  assign clk_pad_fall = !pad_sync[0] && clk_pad_prev;
  assign jtag_mode    = pad_sync[6];

  // SPI side, parked with csb high in JTAG mode
  assign spi_sck_rise_o = clk_pad_rise && !jtag_mode;
  assign spi_sck_fall_o = clk_pad_fall && !jtag_mode;
  assign spi_csb_o      = pad_sync[3] || jtag_mode;
  assign spi_mosi_o     = pad_sync[1] && !jtag_mode;
  assign write_en_o     = pad_sync[7];

  // JTAG side, no tck edges in SPI mode
  assign tck_rise_o = clk_pad_rise && jtag_mode;
  assign tck_fall_o = clk_pad_fall && jtag_mode;
  assign tms_o      = jtag_mode ? pad_sync[3] : 1'b1;
  assign tdi_o      = pad_sync[1] && jtag_mode;
  assign trst_n_o   = pad_sync[4];
  assign srst_n_o   = pad_sync[5];

  assign dps_o = jtag_mode ? tdo_i : miso_i;

endmodule

//--- verilog/dps_pkg.sv
////////////////////
// Constants and enums shared by the pad subsystem RTL and its testbench
// Referenced by scoped name from each user
////////////////////

package dps_pkg;

  // RAM word and SPI data field width
  localparam int WORD_W = 32;

  // SPI command bytes
  typedef enum logic [7:0] {
    SPI_WRITE = 8'h02,
    SPI_READ  = 8'h03
  } spi_op_e;

  // IEEE 1149.1 TAP states, classic encoding
  typedef enum logic [3:0] {
    TAP_EXIT2_DR   = 4'h0,
    TAP_EXIT1_DR   = 4'h1,
    TAP_SHIFT_DR   = 4'h2,
    TAP_PAUSE_DR   = 4'h3,
    TAP_SELECT_IR  = 4'h4,
    TAP_UPDATE_DR  = 4'h5,
    TAP_CAPTURE_DR = 4'h6,
    TAP_SELECT_DR  = 4'h7,
    TAP_EXIT2_IR   = 4'h8,
    TAP_EXIT1_IR   = 4'h9,
    TAP_SHIFT_IR   = 4'hA,
    TAP_PAUSE_IR   = 4'hB,
    TAP_IDLE       = 4'hC,
    TAP_UPDATE_IR  = 4'hD,
    TAP_CAPTURE_IR = 4'hE,
    TAP_RESET      = 4'hF
  } tap_state_e;

  localparam int IR_W = 2;

  // Unlisted codes select BYPASS
  typedef enum logic [IR_W-1:0] {
    IR_IDCODE = 2'b01,
    IR_BYPASS = 2'b11
  } jtag_ir_e;

  // Device ID, bit 0 set as the standard requires
  localparam logic [31:0] JTAG_IDCODE = 32'h14D5_0E53;

  // Codes software writes to the low half of the status word
  typedef enum logic [15:0] {
    TS_BOOT    = 16'h0000,
    TS_IN_TEST = 16'h4354,
    TS_PASSED  = 16'h900D,
    TS_FAILED  = 16'hBAAD
  } test_status_e;

endpackage
